/* logic/riscv_pkg.sv */
package riscv_pkg;

	// PC and instruction word width
	localparam int XLEN = 32;
	// Pipe registers from IF/DEC to MEM/WB
	localparam int N_STAGES = 4;

	// Base opcodes seen by the control path
	localparam logic [6:0] OP_LOAD = 7'b000_0011;
	localparam logic [6:0] OP_STORE = 7'b010_0011;
	localparam logic [6:0] OP_JAL = 7'b110_1111;

	// addi x0, x0, 0
	localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// Command to one pipe register or the PC
	typedef enum logic [1:0] {
		ENABLE,
		STALL,
		FLUSH
	} HAZARD_ctrl;

	// Jump condition from IF/DEC
	typedef enum logic {
		NO_JUMP,
		JUMP
	} IF_ctrl;

	// Data memory direction
	typedef enum logic {
		READ,
		WRITE
	} MEM_dir;

	typedef struct packed {
		logic mem_en;
		MEM_dir wr;
	} MEM_ctrl;

	// Register view of the word
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_r_t;

	// Jump view with the scattered immediate
	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_j_t;

	// Same 32 bits decoded both ways
	typedef union packed {
		instr_r_t r;
		instr_j_t j;
	} instr_u;

endpackage

/* logic/hu.sv */
`timescale 1ns/100ps

module hu (
	input logic CLK,
	input logic RSTn,
	input logic EN,
	input riscv_pkg::IF_ctrl BRANCH_cond_in,
	input logic INSTR_mem_busy_in,
	input logic DATA_mem_busy_in,
	input riscv_pkg::MEM_ctrl MEMctrl_in,
	input logic [4:0] EX_MEM_RD_in,
	input logic [4:0] DEC_EX_RS1_in,
	input logic [4:0] DEC_EX_RS2_in,
	output logic HZ_instr_req,
	output logic HZ_data_req,
	output riscv_pkg::HAZARD_ctrl PC_REG_out,
	output riscv_pkg::HAZARD_ctrl IF_DEC_out,
	output riscv_pkg::HAZARD_ctrl DEC_EX_out,
	output riscv_pkg::HAZARD_ctrl EX_MEM_out,
	output riscv_pkg::HAZARD_ctrl MEM_WB_out
);

	import riscv_pkg::*;

	// Which memory currently holds the pipe
	typedef enum logic [1:0] {
		issue_req,
		instr_busy,
		data_busy,
		idle
	} hu_state_t;

	hu_state_t current_state;
	hu_state_t next_state;
	logic freeze;
	logic load_use;

	// Either busy level, a wait state or a global disable freezes everything
	assign freeze = !EN || (current_state != issue_req) ||
		INSTR_mem_busy_in || DATA_mem_busy_in;

	// Load in EX/MEM whose rd feeds a DEC/EX source
	assign load_use = MEMctrl_in.mem_en && (MEMctrl_in.wr == READ) &&
		((EX_MEM_RD_in == DEC_EX_RS1_in) || (EX_MEM_RD_in == DEC_EX_RS2_in));

	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			current_state <= issue_req;
		end else if (EN) begin
			current_state <= next_state;
		end
	end

	always_comb begin : hu_next
		next_state = current_state;
		case (current_state)
			issue_req, idle: begin
				// Sample both memories afresh
				if (INSTR_mem_busy_in && DATA_mem_busy_in) begin
					next_state = idle;
				end else if (INSTR_mem_busy_in) begin
					next_state = instr_busy;
				end else if (DATA_mem_busy_in) begin
					next_state = data_busy;
				end else begin
					next_state = issue_req;
				end
			end
			instr_busy: begin
				// Waiting on fetch side
				if (INSTR_mem_busy_in) begin
					next_state = DATA_mem_busy_in ? idle : instr_busy;
				end else if (DATA_mem_busy_in) begin
					next_state = data_busy;
				end else begin
					next_state = issue_req;
				end
			end
			data_busy: begin
				// Waiting on load/store side
				if (DATA_mem_busy_in) begin
					next_state = INSTR_mem_busy_in ? idle : data_busy;
				end else if (INSTR_mem_busy_in) begin
					next_state = instr_busy;
				end else begin
					next_state = issue_req;
				end
			end
			default: begin
				next_state = issue_req;
			end
		endcase
	end

	// Mealy outputs from the state and the live busy levels
	always_comb begin : hu_out
		PC_REG_out = ENABLE;
		IF_DEC_out = ENABLE;
		DEC_EX_out = ENABLE;
		EX_MEM_out = ENABLE;
		MEM_WB_out = ENABLE;
		HZ_instr_req = 1'b1;
		HZ_data_req = 1'b1;
		if (freeze) begin
			// Hold every register and withdraw both strobes
			HZ_instr_req = 1'b0;
			HZ_data_req = 1'b0;
			PC_REG_out = STALL;
			IF_DEC_out = STALL;
			DEC_EX_out = STALL;
			EX_MEM_out = STALL;
			MEM_WB_out = STALL;
		end else begin
			// Only reached in issue_req with both memories free
			// Wrong-path word behind a JAL becomes a bubble
			if (BRANCH_cond_in == JUMP) begin
				IF_DEC_out = FLUSH;
			end
			// Load-use wins over the jump
			if (load_use) begin
				PC_REG_out = STALL;
				IF_DEC_out = STALL;
				DEC_EX_out = FLUSH;
			end
		end
	end

	// A held fetch never kills a register in the busy states
	assert property (@(posedge CLK) disable iff (!RSTn)
		(current_state != issue_req && INSTR_mem_busy_in) |->
		(PC_REG_out != FLUSH && IF_DEC_out != FLUSH && DEC_EX_out != FLUSH &&
		EX_MEM_out != FLUSH && MEM_WB_out != FLUSH))
		else $error("hu: FLUSH issued while instruction memory busy");

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit (
	input logic CLK,
	input logic RSTn,
	input riscv_pkg::HAZARD_ctrl pc_ctrl,
	input logic instr_req_en,
	input logic [riscv_pkg::XLEN-1:0] instr_rdata,
	input logic instr_busy,
	input logic [riscv_pkg::XLEN-1:0] if_dec_pc,
	input riscv_pkg::instr_u if_dec_instr,
	input logic if_dec_valid,
	output logic [riscv_pkg::XLEN-1:0] instr_addr,
	output logic [riscv_pkg::XLEN-1:0] fetch_pc,
	output logic instr_req,
	output logic fetch_valid,
	output riscv_pkg::instr_u fetch_instr,
	output riscv_pkg::IF_ctrl branch_cond
);

	import riscv_pkg::*;

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_next;
	logic [XLEN-1:0] jal_imm;
	logic [XLEN-1:0] jal_target;
	logic fetch_armed;

	// J immediate rebuilt with bit 0 forced low
	assign jal_imm = {{11{if_dec_instr.j.imm20}}, if_dec_instr.j.imm20,
		if_dec_instr.j.imm19_12, if_dec_instr.j.imm11,
		if_dec_instr.j.imm10_1, 1'b0};
	assign jal_target = if_dec_pc + jal_imm;

	// Only a valid JAL in IF/DEC redirects
	assign branch_cond = (if_dec_valid && if_dec_instr.j.opcode == OP_JAL) ? JUMP : NO_JUMP;

	always_comb begin
		pc_next = pc;
		if (pc_ctrl == ENABLE) begin
			if (branch_cond == JUMP) begin
				pc_next = jal_target;
			end else begin
				pc_next = pc + XLEN'(4);
			end
		end
	end

	// First cycle out of reset issues nothing and keeps RESET_PC
	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			pc <= RESET_PC;
			fetch_armed <= 1'b0;
		end else begin
			fetch_armed <= 1'b1;
			if (fetch_armed) begin
				pc <= pc_next;
			end
		end
	end

	assign instr_addr = pc;
	assign fetch_pc = pc;
	assign instr_req = instr_req_en && fetch_armed;
	// memory answers in the same cycle unless busy
	assign fetch_valid = instr_req && !instr_busy;
	assign fetch_instr = instr_rdata;

	// Sequential and JAL targets keep word alignment
	assert property (@(posedge CLK) disable iff (!RSTn) pc[1:0] == 2'b00)
		else $error("fetch_unit: misaligned PC %h", pc);

endmodule

/* logic/pipe_stage.sv */
`timescale 1ns/100ps

module pipe_stage (
	input logic CLK,
	input logic RSTn,
	input riscv_pkg::HAZARD_ctrl ctrl,
	input logic in_valid,
	input logic [riscv_pkg::XLEN-1:0] in_pc,
	input riscv_pkg::instr_u in_instr,
	output logic out_valid,
	output logic [riscv_pkg::XLEN-1:0] out_pc,
	output riscv_pkg::instr_u out_instr
);

	import riscv_pkg::*;

	// Valid bit is the only control state
	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			out_valid <= 1'b0;
		end else begin
			case (ctrl)
				ENABLE: out_valid <= in_valid;
				FLUSH: out_valid <= 1'b0;
				default: out_valid <= out_valid;
			endcase
		end
	end

	// Bubble carries a NOP word
	always_ff @(posedge CLK) begin
		case (ctrl)
			ENABLE: begin
				out_pc <= in_pc;
				out_instr <= in_instr;
			end
			FLUSH: begin
				out_pc <= in_pc;
				out_instr <= NOP_WORD;
			end
			default: begin
				out_pc <= out_pc;
				out_instr <= out_instr;
			end
		endcase
	end

endmodule

/* logic/lsu_retire.sv */
`timescale 1ns/100ps

module lsu_retire (
	input logic CLK,
	input logic RSTn,
	input logic data_req_en,
	input logic ex_mem_valid,
	input riscv_pkg::instr_u ex_mem_instr,
	input riscv_pkg::HAZARD_ctrl mem_wb_ctrl,
	input logic mem_wb_valid,
	input logic [riscv_pkg::XLEN-1:0] mem_wb_pc,
	input riscv_pkg::instr_u mem_wb_instr,
	output riscv_pkg::MEM_ctrl mem_ctrl,
	output logic data_req,
	output logic data_we,
	output logic retire_valid,
	output logic [riscv_pkg::XLEN-1:0] retire_pc,
	output riscv_pkg::instr_u retire_instr
);

	import riscv_pkg::*;

	logic is_load;
	logic is_store;
	logic retire_now;

	// Opcode decode of the EX/MEM word
	assign is_load = ex_mem_valid && (ex_mem_instr.r.opcode == OP_LOAD);
	assign is_store = ex_mem_valid && (ex_mem_instr.r.opcode == OP_STORE);

	always_comb begin
		mem_ctrl.mem_en = is_load || is_store;
		mem_ctrl.wr = is_store ? WRITE : READ;
	end

	// Strobe only when the hazard unit lets the access go
	assign data_req = data_req_en && mem_ctrl.mem_en;
	assign data_we = data_req && (mem_ctrl.wr == WRITE);

	// MEM/WB advancing with real content
	assign retire_now = (mem_wb_ctrl == ENABLE) && mem_wb_valid;

	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= retire_now;
		end
	end

	// Retired word held until the next one
	always_ff @(posedge CLK) begin
		if (retire_now) begin
			retire_pc <= mem_wb_pc;
			retire_instr <= mem_wb_instr;
		end
	end

endmodule

/* logic/pipeline_ctrl.sv */
`timescale 1ns/100ps

module pipeline_ctrl (
	input logic CLK,
	input logic RSTn,
	input logic [riscv_pkg::XLEN-1:0] instr_rdata,
	input logic instr_busy,
	input logic data_busy,
	output logic [riscv_pkg::XLEN-1:0] instr_addr,
	output logic instr_req,
	output logic data_req,
	output logic data_we,
	output logic retire_valid,
	output logic [riscv_pkg::XLEN-1:0] retire_pc,
	output logic [riscv_pkg::XLEN-1:0] retire_instr
);

	import riscv_pkg::*;

	// Slot 0 is the fetch output and slot i+1 is stage i
	logic stg_valid [0:N_STAGES];
	logic [XLEN-1:0] stg_pc [0:N_STAGES];
	instr_u stg_instr [0:N_STAGES];
	HAZARD_ctrl stg_ctrl [0:N_STAGES-1];

	HAZARD_ctrl pc_ctrl;
	IF_ctrl branch_cond;
	MEM_ctrl mem_ctrl;
	logic hz_instr_req;
	logic hz_data_req;
	instr_u retire_word;

	fetch_unit fetch_unit_inst (
		.CLK(CLK),
		.RSTn(RSTn),
		.pc_ctrl(pc_ctrl),
		.instr_req_en(hz_instr_req),
		.instr_rdata(instr_rdata),
		.instr_busy(instr_busy),
		.if_dec_pc(stg_pc[1]),
		.if_dec_instr(stg_instr[1]),
		.if_dec_valid(stg_valid[1]),
		.instr_addr(instr_addr),
		.fetch_pc(stg_pc[0]),
		.instr_req(instr_req),
		.fetch_valid(stg_valid[0]),
		.fetch_instr(stg_instr[0]),
		.branch_cond(branch_cond)
	);

	// IF/DEC, DEC/EX, EX/MEM, MEM/WB
	for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
		pipe_stage pipe_stage_inst (
			.CLK(CLK),
			.RSTn(RSTn),
			.ctrl(stg_ctrl[i]),
			.in_valid(stg_valid[i]),
			.in_pc(stg_pc[i]),
			.in_instr(stg_instr[i]),
			.out_valid(stg_valid[i+1]),
			.out_pc(stg_pc[i+1]),
			.out_instr(stg_instr[i+1])
		);
	end

	// Global enable lives outside this block
	hu hu_inst (
		.CLK(CLK),
		.RSTn(RSTn),
		.EN(1'b1),
		.BRANCH_cond_in(branch_cond),
		.INSTR_mem_busy_in(instr_busy),
		.DATA_mem_busy_in(data_busy),
		.MEMctrl_in(mem_ctrl),
		.EX_MEM_RD_in(stg_instr[3].r.rd),
		.DEC_EX_RS1_in(stg_instr[2].r.rs1),
		.DEC_EX_RS2_in(stg_instr[2].r.rs2),
		.HZ_instr_req(hz_instr_req),
		.HZ_data_req(hz_data_req),
		.PC_REG_out(pc_ctrl),
		.IF_DEC_out(stg_ctrl[0]),
		.DEC_EX_out(stg_ctrl[1]),
		.EX_MEM_out(stg_ctrl[2]),
		.MEM_WB_out(stg_ctrl[3])
	);

	lsu_retire lsu_retire_inst (
		.CLK(CLK),
		.RSTn(RSTn),
		.data_req_en(hz_data_req),
		.ex_mem_valid(stg_valid[3]),
		.ex_mem_instr(stg_instr[3]),
		.mem_wb_ctrl(stg_ctrl[3]),
		.mem_wb_valid(stg_valid[4]),
		.mem_wb_pc(stg_pc[4]),
		.mem_wb_instr(stg_instr[4]),
		.mem_ctrl(mem_ctrl),
		.data_req(data_req),
		.data_we(data_we),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_instr(retire_word)
	);

	assign retire_instr = retire_word;

	// Data strobe never meets a busy data memory
	assert property (@(posedge CLK) disable iff (!RSTn) data_busy |-> !data_req)
		else $error("pipeline_ctrl: data_req high while data_busy");

	// Fetch back-pressure also blocks loads and stores
	assert property (@(posedge CLK) disable iff (!RSTn) instr_busy |-> !data_req)
		else $error("pipeline_ctrl: data_req high while instr_busy");

endmodule

/* verification/pipeline_ctrl_mem_chk.sv */
`timescale 1ns/100ps

module pipeline_ctrl_mem_chk #(
	parameter int MAX_STRETCH = 4
) (
	input logic CLK,
	input logic RSTn,
	input logic instr_busy_on,
	input logic data_busy_on,
	input logic [riscv_pkg::XLEN-1:0] instr_addr,
	input logic instr_req,
	input logic data_req,
	input logic data_we,
	input logic retire_valid,
	input logic [riscv_pkg::XLEN-1:0] retire_pc,
	input logic [riscv_pkg::XLEN-1:0] retire_instr,
	output logic [riscv_pkg::XLEN-1:0] instr_rdata,
	output logic instr_busy,
	output logic data_busy,
	output logic prog_done,
	output logic chk_failed
);

	import riscv_pkg::*;

	localparam int DEPTH = 64;
	// Self-looping JAL at word 19 ends the program
	localparam logic [XLEN-1:0] END_PC = 32'h0000_004c;
	// No memory access left on the path
	localparam logic [XLEN-1:0] NO_MEM = 32'hffff_fffc;

	logic [XLEN-1:0] prog [0:DEPTH-1];
	logic [XLEN-1:0] jal_to [0:DEPTH-1];
	logic is_jal [0:DEPTH-1];
	logic is_mem [0:DEPTH-1];
	logic is_st [0:DEPTH-1];
	logic [XLEN-1:0] exp_pc;
	logic [XLEN-1:0] mem_pc;
	int loop_hits;
	int busy_left;
	integer seed = 32'h4d6b_d52c;

	function automatic logic [XLEN-1:0] addi_word(input logic [4:0] rd, input logic [11:0] imm);
		return {imm, 5'd0, 3'b000, rd, 7'b001_0011};
	endfunction

	function automatic logic [XLEN-1:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		return {7'd0, rs2, rs1, 3'b000, rd, 7'b011_0011};
	endfunction

	// lw rd, 0(rs1)
	function automatic logic [XLEN-1:0] load_word(input logic [4:0] rd, input logic [4:0] rs1);
		return {12'd0, rs1, 3'b010, rd, OP_LOAD};
	endfunction

	// sw rs2, 0(rs1)
	function automatic logic [XLEN-1:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1);
		return {7'd0, rs2, rs1, 3'b010, 5'd0, OP_STORE};
	endfunction

	task automatic place(input int i, input logic [XLEN-1:0] word, input logic mem,
		input logic st);
		prog[i] = word;
		jal_to[i] = '0;
		is_jal[i] = 1'b0;
		is_mem[i] = mem;
		is_st[i] = st;
	endtask

	// jal x0 with a word offset, target kept alongside
	task automatic place_jal(input int i, input int words);
		logic [20:0] off;
		off = 21'(words * 4);
		prog[i] = {off[20], off[10:1], off[11], off[19:12], 5'd0, OP_JAL};
		jal_to[i] = XLEN'(i * 4 + words * 4);
		is_jal[i] = 1'b1;
		is_mem[i] = 1'b0;
		is_st[i] = 1'b0;
	endtask

	// Architectural successor of a PC
	function automatic logic [XLEN-1:0] next_pc(input logic [XLEN-1:0] pc);
		return is_jal[pc[7:2]] ? jal_to[pc[7:2]] : pc + 32'd4;
	endfunction

	// First load or store on the path from pc onward
	function automatic logic [XLEN-1:0] next_mem(input logic [XLEN-1:0] pc);
		logic [XLEN-1:0] walk;
		walk = pc;
		for (int k = 0; k < DEPTH; k++) begin
			if (is_mem[walk[7:2]]) begin
				return walk;
			end
			walk = next_pc(walk);
		end
		return NO_MEM;
	endfunction

	initial begin : load_program
		chk_failed = 1'b0;
		instr_busy = 1'b0;
		data_busy = 1'b0;
		busy_left = 0;
		// Unused words are addi x1 with their own address
		for (int i = 0; i < DEPTH; i++) begin
			place(i, addi_word(5'd1, 12'(i * 4)), 1'b0, 1'b0);
		end
		// Straight-line block
		place(0, addi_word(5'd1, 12'd1), 1'b0, 1'b0);
		place(1, addi_word(5'd2, 12'd2), 1'b0, 1'b0);
		place(2, addi_word(5'd3, 12'd3), 1'b0, 1'b0);
		place(3, addi_word(5'd4, 12'd4), 1'b0, 1'b0);
		// Forward jump over a store that must never issue
		place_jal(4, 3);
		place(5, store_word(5'd1, 5'd2), 1'b1, 1'b1);
		place(6, addi_word(5'd12, 12'd6), 1'b0, 1'b0);
		// Load-use on rs1, then on rs2
		place(7, load_word(5'd5, 5'd1), 1'b1, 1'b0);
		place(8, add_word(5'd6, 5'd5, 5'd2), 1'b0, 1'b0);
		place(9, load_word(5'd7, 5'd1), 1'b1, 1'b0);
		place(10, add_word(5'd8, 5'd2, 5'd7), 1'b0, 1'b0);
		// back-to-back stores
		place(11, store_word(5'd8, 5'd1), 1'b1, 1'b1);
		place(12, store_word(5'd6, 5'd1), 1'b1, 1'b1);
		place(13, load_word(5'd9, 5'd2), 1'b1, 1'b0);
		place(14, add_word(5'd10, 5'd9, 5'd9), 1'b0, 1'b0);
		place(15, addi_word(5'd11, 12'd5), 1'b0, 1'b0);
		// Skipped load on the wrong path
		place_jal(16, 2);
		place(17, load_word(5'd13, 5'd1), 1'b1, 1'b0);
		place(18, addi_word(5'd14, 12'd7), 1'b0, 1'b0);
		place_jal(19, 0);
	end

	// Same-cycle instruction memory
	assign instr_rdata = prog[instr_addr[7:2]];

	// Busy stretches of 1..MAX_STRETCH cycles, always followed by a free cycle
	always @(negedge CLK) begin : busy_gen
		logic [31:0] pick;
		if (busy_left > 0) begin
			busy_left = busy_left - 1;
			if (busy_left == 0) begin
				instr_busy <= 1'b0;
				data_busy <= 1'b0;
			end
		end else if (($random(seed) & 3) == 0) begin
			pick = $random(seed);
			instr_busy <= instr_busy_on && pick[0];
			data_busy <= data_busy_on && pick[1];
			busy_left = 1 + int'(pick[7:4]) % MAX_STRETCH;
		end
	end

	// Reference order of retired PCs and of data accesses
	always @(posedge CLK) begin : ref_model
		if (!RSTn) begin
			exp_pc <= RESET_PC;
			mem_pc <= next_mem(RESET_PC);
			loop_hits <= 0;
		end else begin
			if (retire_valid) begin
				exp_pc <= next_pc(exp_pc);
				if (exp_pc == END_PC) begin
					loop_hits <= loop_hits + 1;
				end
			end
			if (data_req) begin
				mem_pc <= next_mem(next_pc(mem_pc));
			end
		end
	end

	// Terminator seen a few times
	assign prog_done = (loop_hits >= 3);

	assert property (@(posedge CLK) disable iff (!RSTn) retire_valid |-> retire_pc == exp_pc)
		else begin
			$display("FAILED retire_pc: expected %h, got %h", $sampled(exp_pc),
				$sampled(retire_pc));
			chk_failed = 1'b1;
		end

	assert property (@(posedge CLK) disable iff (!RSTn)
		retire_valid |-> retire_instr == prog[exp_pc[7:2]])
		else begin
			$display("FAILED retire_instr: expected %h, got %h",
				prog[$sampled(exp_pc[7:2])], $sampled(retire_instr));
			chk_failed = 1'b1;
		end

	assert property (@(posedge CLK) disable iff (!RSTn) data_busy |-> !data_req)
		else begin
			$display("FAILED data_req with data_busy: expected %h, got %h", 1'b0,
				$sampled(data_req));
			chk_failed = 1'b1;
		end

	assert property (@(posedge CLK) disable iff (!RSTn) instr_busy |-> !data_req)
		else begin
			$display("FAILED data_req with instr_busy: expected %h, got %h", 1'b0,
				$sampled(data_req));
			chk_failed = 1'b1;
		end

	assert property (@(posedge CLK) disable iff (!RSTn) data_req |-> mem_pc != NO_MEM)
		else begin
			$display("Data request issued after the last load or store of the program");
			chk_failed = 1'b1;
		end

	// Store or load as the program order says
	assert property (@(posedge CLK) disable iff (!RSTn) data_req |-> data_we == is_st[mem_pc[7:2]])
		else begin
			$display("FAILED data_we: expected %h, got %h", is_st[$sampled(mem_pc[7:2])],
				$sampled(data_we));
			chk_failed = 1'b1;
		end

	// Quiet outputs on the first cycle out of reset
	assert property (@(posedge CLK) $rose(RSTn) |-> !retire_valid && !data_req && !instr_req)
		else begin
			$display("FAILED retire_valid/data_req/instr_req: expected 0/0/0, got %h/%h/%h",
				$sampled(retire_valid), $sampled(data_req), $sampled(instr_req));
			chk_failed = 1'b1;
		end

endmodule

/* verification/pipeline_ctrl_tb.sv */
`timescale 1ns/100ps

module pipeline_ctrl_tb;

	import riscv_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int N_PHASES = 4;
	localparam int PROG_WORDS = 20;
	localparam int MAX_STRETCH = 4;
	// Every pipeline step may wait out a full stretch plus its free cycle
	localparam int PHASE_CYCLES = RESET_CYCLES +
		2 * (PROG_WORDS + N_STAGES + 4) * (MAX_STRETCH + 1);
	localparam longint WATCHDOG_NS = longint'(N_PHASES) * PHASE_CYCLES * CLK_PERIOD;

	logic CLK;
	logic RSTn;
	logic [XLEN-1:0] instr_rdata;
	logic instr_busy;
	logic data_busy;
	logic [XLEN-1:0] instr_addr;
	logic instr_req;
	logic data_req;
	logic data_we;
	logic retire_valid;
	logic [XLEN-1:0] retire_pc;
	logic [XLEN-1:0] retire_instr;
	logic instr_busy_on;
	logic data_busy_on;
	logic prog_done;
	logic chk_failed;

	pipeline_ctrl pipeline_ctrl_inst (
		.CLK(CLK),
		.RSTn(RSTn),
		.instr_rdata(instr_rdata),
		.instr_busy(instr_busy),
		.data_busy(data_busy),
		.instr_addr(instr_addr),
		.instr_req(instr_req),
		.data_req(data_req),
		.data_we(data_we),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr)
	);

	// Program memory, busy sources and the order checks
	pipeline_ctrl_mem_chk #(
		.MAX_STRETCH(MAX_STRETCH)
	) mem_chk_inst (
		.CLK(CLK),
		.RSTn(RSTn),
		.instr_busy_on(instr_busy_on),
		.data_busy_on(data_busy_on),
		.instr_addr(instr_addr),
		.instr_req(instr_req),
		.data_req(data_req),
		.data_we(data_we),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr),
		.instr_rdata(instr_rdata),
		.instr_busy(instr_busy),
		.data_busy(data_busy),
		.prog_done(prog_done),
		.chk_failed(chk_failed)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped");
	endtask

	// Called on a falling edge
	task automatic apply_reset();
		RSTn = 1'b0;
		repeat (RESET_CYCLES) @(negedge CLK);
		RSTn = 1'b1;
	endtask

	// One full program run under the given back-pressure
	task automatic run_phase(input logic instr_on, input logic data_on);
		@(negedge CLK);
		instr_busy_on = instr_on;
		data_busy_on = data_on;
		apply_reset();
		wait (prog_done === 1'b1);
	endtask

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		RSTn = 1'b0;
		instr_busy_on = 1'b0;
		data_busy_on = 1'b0;
		// Clean run first, then fetch stalls, data stalls, both
		run_phase(1'b0, 1'b0);
		run_phase(1'b1, 1'b0);
		run_phase(1'b0, 1'b1);
		run_phase(1'b1, 1'b1);
		if (chk_failed) begin
			abort_run("A check failed before the end of the run");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

	// First failed check ends the run
	initial begin
		wait (chk_failed === 1'b1);
		abort_run("Stopping at the first failed check");
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run($sformatf("Timeout after %0d ns with the program unfinished", WATCHDOG_NS));
	end

endmodule

/* build.f */
logic/riscv_pkg.sv
logic/hu.sv
logic/fetch_unit.sv
logic/pipe_stage.sv
logic/lsu_retire.sv
logic/pipeline_ctrl.sv
verification/pipeline_ctrl_mem_chk.sv
verification/pipeline_ctrl_tb.sv

/* Bender.yml */
package:
  name: pipeline_ctrl

sources:
  - logic/riscv_pkg.sv
  - logic/hu.sv
  - logic/fetch_unit.sv
  - logic/pipe_stage.sv
  - logic/lsu_retire.sv
  - logic/pipeline_ctrl.sv
  - target: simulation
    files:
      - verification/pipeline_ctrl_mem_chk.sv
      - verification/pipeline_ctrl_tb.sv
